/* Makefile */
# Verilator build and run of the execute cluster testbench
VERILATOR ?= verilator
TOP       ?= rv32_exec_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "No pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+src
src/rv32_isa_pkg.sv
src/rv32_flow_pkg.sv
src/rv32_alu_pipe.sv
src/rv32_mul_div.sv
src/rv32_result_merge.sv
src/rv32_exec_cluster.sv
sim/rv32_exec_tb.sv

/* sim/rv32_exec_tb.sv */
`timescale 1ns/1ns
`include "rv32_exec_cfg.svh"

module rv32_exec_tb;
    import rv32_isa_pkg::*;

    localparam int NUM_TAGS      = 1 << `TAG_WIDTH;
    localparam int DIV_CYCLES    = 34;
    localparam int HOLD_CYCLES   = `ISSUE_CREDITS * (DIV_CYCLES + 2) + 4;
    localparam int ISSUE_TIMEOUT = 400;
    localparam int DRAIN_TIMEOUT = 500;
    localparam int RANDOM_OPS    = 400;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  issue_valid_i;
    exec_op_e              issue_op_i;
    logic [`XLEN-1:0]      issue_a_i;
    logic [`XLEN-1:0]      issue_b_i;
    logic [`TAG_WIDTH-1:0] issue_tag_i;
    logic                  issue_credit_o;
    logic                  res_credit_i;
    logic                  res_valid_o;
    logic [`TAG_WIDTH-1:0] res_tag_o;
    logic [`XLEN-1:0]      res_data_o;

    // Scoreboard by tag
    logic [`XLEN-1:0] exp_data [NUM_TAGS];
    exec_op_e         exp_op   [NUM_TAGS];
    bit               pending  [NUM_TAGS];

    integer seed = 32'h7bfce77c;
    int     issue_credits;  // Issuer side
    int     granted;        // Result credits given but not yet used
    int     in_flight;
    int     next_tag;
    int     errors;
    bit     auto_credit;
    bit     random_credit;
    bit     expect_quiet;

    exec_op_e alu_ops [10] = '{OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                               OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND};
    exec_op_e m_ops [8] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                            OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    logic [`XLEN-1:0] edge_vals [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                       32'h8000_0000, 32'h7fff_ffff};

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    rv32_exec_cluster rv32_exec_cluster_i (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .issue_valid_i(issue_valid_i),
        .issue_op_i(issue_op_i),
        .issue_a_i(issue_a_i),
        .issue_b_i(issue_b_i),
        .issue_tag_i(issue_tag_i),
        .issue_credit_o(issue_credit_o),
        .res_credit_i(res_credit_i),
        .res_valid_o(res_valid_o),
        .res_tag_o(res_tag_o),
        .res_data_o(res_data_o)
    );

    // Expected result straight from the RV32IM rules
    function automatic logic [`XLEN-1:0] model_result(input exec_op_e op,
                                                      input logic [`XLEN-1:0] a,
                                                      input logic [`XLEN-1:0] b);
        logic [63:0]      wide;
        logic [`XLEN-1:0] res;
        logic             ovf;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            OP_ADD:    res = a + b;
            OP_SUB:    res = a - b;
            OP_SLL:    res = a << b[4:0];
            OP_SLT:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU:   res = (a < b) ? 32'd1 : 32'd0;
            OP_XOR:    res = a ^ b;
            OP_SRL:    res = a >> b[4:0];
            OP_SRA: begin
                wide = {{32{a[31]}}, a} >> b[4:0];  // Sign bits shift in from above
                res  = wide[31:0];
            end
            OP_OR:     res = a | b;
            OP_AND:    res = a & b;
            OP_MUL, OP_MULHU: begin
                wide = {32'b0, a} * {32'b0, b};
                res  = (op == OP_MUL) ? wide[31:0] : wide[63:32];
            end
            OP_MULH: begin
                wide = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                res  = wide[63:32];
            end
            OP_MULHSU: begin
                wide = {{32{a[31]}}, a} * {32'b0, b};
                res  = wide[63:32];
            end
            OP_DIV: begin
                if (b == 0) begin
                    res = 32'hffff_ffff;
                end else if (ovf) begin
                    res = a;
                end else begin
                    res = $signed(a) / $signed(b);
                end
            end
            OP_REM: begin
                if (b == 0) begin
                    res = a;
                end else if (ovf) begin
                    res = 32'd0;
                end else begin
                    res = $signed(a) % $signed(b);  // Sign follows the dividend
                end
            end
            OP_DIVU:   res = (b == 0) ? 32'hffff_ffff : a / b;
            OP_REMU:   res = (b == 0) ? a : a % b;
            default:   res = '0;
        endcase
        return res;
    endfunction

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at %0t ns", $time);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("ERROR @ %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    // One cycle of result port and credit pulse checks
    task automatic sample_outputs();
        int t;
        check_value("issue credit pulse vs result", 32'(issue_credit_o), 32'(res_valid_o));
        if (expect_quiet) begin
            check_value("res_valid_o while no result may leave", 32'(res_valid_o), 32'd0);
        end
        if (issue_credit_o) begin
            issue_credits++;
        end
        if (res_valid_o) begin
            t = int'(res_tag_o);
            check_value("result sent without credit", 32'(granted > 0), 32'd1);
            check_value($sformatf("tag %0d pending", t), 32'(pending[t]), 32'd1);
            check_value($sformatf("%s result, tag %0d", exp_op[t].name(), t),
                        res_data_o, exp_data[t]);
            pending[t] = 1'b0;
            granted--;
            in_flight--;
        end
    endtask

    task automatic tick();
        logic [31:0] r;
        @(negedge clk_i);
        if (rst_n_i) begin
            sample_outputs();
        end
        issue_valid_i = 1'b0;
        res_credit_i  = 1'b0;
        r = $random(seed);
        // Never more credits than results still owed
        if (auto_credit && granted < in_flight && (!random_credit || r[0])) begin
            res_credit_i = 1'b1;
            granted++;
        end
    endtask

    task automatic issue_op(input exec_op_e op, input logic [`XLEN-1:0] a,
                            input logic [`XLEN-1:0] b);
        int waited;
        int t;
        waited = 0;
        while (issue_credits == 0) begin
            if (waited == ISSUE_TIMEOUT) begin
                $display("Timeout: no issue credit came back within %0d cycles", waited);
                stop_with_failure();
            end
            tick();
            waited++;
        end
        t = next_tag;
        while (pending[t]) begin
            t = (t + 1) % NUM_TAGS;
        end
        next_tag    = (t + 1) % NUM_TAGS;
        exp_op[t]   = op;
        exp_data[t] = model_result(op, a, b);
        pending[t]  = 1'b1;
        issue_credits--;
        in_flight++;
        issue_valid_i = 1'b1;
        issue_op_i    = op;
        issue_a_i     = a;
        issue_b_i     = b;
        issue_tag_i   = t[`TAG_WIDTH-1:0];
        tick();
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (in_flight != 0) begin
            if (waited == DRAIN_TIMEOUT) begin
                $display("Timeout: %0d results still missing after %0d cycles",
                         in_flight, waited);
                stop_with_failure();
            end
            tick();
            waited++;
        end
    endtask

    // Edge operand grid plus a few random pairs
    task automatic run_op_set(input exec_op_e op);
        foreach (edge_vals[j]) begin
            foreach (edge_vals[k]) begin
                issue_op(op, edge_vals[j], edge_vals[k]);
            end
        end
        for (int n = 0; n < 8; n++) begin
            issue_op(op, $random(seed), $random(seed));
        end
    endtask

    task automatic test_reset_quiet();
        expect_quiet = 1'b1;
        res_credit_i = 1'b1;  // A held credit alone must not release a result
        granted++;
        for (int i = 0; i < 8; i++) begin
            tick();
        end
        expect_quiet = 1'b0;
    endtask

    task automatic test_alu_ops();
        auto_credit = 1'b1;
        foreach (alu_ops[i]) begin
            run_op_set(alu_ops[i]);
        end
        drain_results();
    endtask

    task automatic test_m_ops();
        auto_credit = 1'b1;
        foreach (m_ops[i]) begin
            run_op_set(m_ops[i]);
        end
        for (int i = 4; i < 8; i++) begin
            issue_op(m_ops[i], $random(seed), 32'h0);  // Divide by zero
        end
        issue_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        issue_op(OP_REM, 32'h8000_0000, 32'hffff_ffff);
        drain_results();
    endtask

    task automatic test_mixed_inflight();
        auto_credit = 1'b1;
        issue_op(OP_DIV, $random(seed), 32'h0000_0007);
        issue_op(OP_ADD, $random(seed), $random(seed));
        issue_op(OP_REMU, $random(seed), 32'h0001_0003);
        issue_op(OP_XOR, $random(seed), $random(seed));
        for (int n = 0; n < 12; n++) begin
            issue_op(alu_ops[n % 10], $random(seed), $random(seed));
        end
        drain_results();
    endtask

    task automatic test_back_pressure();
        auto_credit  = 1'b0;
        expect_quiet = 1'b1;
        issue_op(OP_DIVU, $random(seed), 32'h0000_0035);
        issue_op(OP_SUB, $random(seed), $random(seed));
        issue_op(OP_MULHU, $random(seed), $random(seed));
        issue_op(OP_SLT, $random(seed), $random(seed));
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            tick();
        end
        expect_quiet = 1'b0;
        auto_credit  = 1'b1;
        drain_results();
    endtask

    task automatic test_random_run();
        logic [31:0] r;
        auto_credit   = 1'b1;
        random_credit = 1'b1;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                issue_op(m_ops[r[10:8]], $random(seed), $random(seed));
            end else begin
                issue_op(alu_ops[r[15:8] % 10], $random(seed), $random(seed));
            end
            if (r[4]) begin
                tick();  // Idle gap
            end
        end
        drain_results();
        random_credit = 1'b0;
    endtask

    initial begin
        rst_n_i        = 1'b0;
        issue_valid_i  = 1'b0;
        issue_op_i     = OP_ADD;
        issue_a_i      = '0;
        issue_b_i      = '0;
        issue_tag_i    = '0;
        res_credit_i   = 1'b0;
        issue_credits  = `ISSUE_CREDITS;
        granted        = 0;
        in_flight      = 0;
        next_tag       = 0;
        errors         = 0;
        auto_credit    = 1'b0;
        random_credit  = 1'b0;
        expect_quiet   = 1'b0;
        foreach (pending[i]) begin
            pending[i] = 1'b0;
        end
        for (int i = 0; i < 4; i++) begin
            tick();
        end
        rst_n_i = 1'b1;

        test_reset_quiet();
        test_alu_ops();
        test_m_ops();
        test_mixed_inflight();
        test_back_pressure();
        test_random_run();

        if (errors == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

/* src/rv32_alu_pipe.sv */
`timescale 1ns/1ns
`include "rv32_exec_cfg.svh"

module rv32_alu_pipe (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   op_valid_i,
    input  rv32_isa_pkg::exec_op_e op_i,
    input  logic [`XLEN-1:0]       op_a_i,
    input  logic [`XLEN-1:0]       op_b_i,
    input  rv32_flow_pkg::tag_t    op_tag_i,
    output logic                   res_valid_o,
    output rv32_flow_pkg::tag_t    res_tag_o,
    output logic [`XLEN-1:0]       res_data_o
);
    import rv32_isa_pkg::*;
    import rv32_flow_pkg::*;

    logic             s1_valid;
    exec_op_e         s1_op;
    logic [`XLEN-1:0] s1_a, s1_b;
    tag_t             s1_tag;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_result;

    // Stage one, capture ALU ops only
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= op_valid_i && !is_muldiv(op_i);
        end
    end

    always_ff @(posedge clk_i) begin
        s1_op  <= op_i;
        s1_a   <= op_a_i;
        s1_b   <= op_b_i;
        s1_tag <= op_tag_i;
    end

    assign shamt = s1_b[4:0];

    always_comb begin
        case (s1_op)
            OP_ADD:  alu_result = s1_a + s1_b;
            OP_SUB:  alu_result = s1_a - s1_b;
            OP_SLL:  alu_result = s1_a << shamt;
            OP_SLT:  alu_result = `XLEN'($signed(s1_a) < $signed(s1_b));
            OP_SLTU: alu_result = `XLEN'(s1_a < s1_b);
            OP_XOR:  alu_result = s1_a ^ s1_b;
            OP_SRL:  alu_result = s1_a >> shamt;
            OP_SRA:  alu_result = $signed(s1_a) >>> shamt;  // Keeps sign
            OP_OR:   alu_result = s1_a | s1_b;
            OP_AND:  alu_result = s1_a & s1_b;
            default: alu_result = '0;
        endcase
    end

    // Stage two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        res_tag_o  <= s1_tag;
        res_data_o <= alu_result;
    end

endmodule

/* src/rv32_exec_cfg.svh */
`ifndef RV32_EXEC_CFG_SVH
`define RV32_EXEC_CFG_SVH

// Datapath width
`define XLEN 32
`define TAG_WIDTH 4

// Issuer starts with this many credits, bounds ops in flight
`define ISSUE_CREDITS 4

// Merge buffer holds every op that can be in flight
`define RESULT_DEPTH `ISSUE_CREDITS

`endif

/* src/rv32_exec_cluster.sv */
`timescale 1ns/1ns
`include "rv32_exec_cfg.svh"

module rv32_exec_cluster (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   issue_valid_i,
    input  rv32_isa_pkg::exec_op_e issue_op_i,
    input  logic [`XLEN-1:0]       issue_a_i,
    input  logic [`XLEN-1:0]       issue_b_i,
    input  rv32_flow_pkg::tag_t    issue_tag_i,
    output logic                   issue_credit_o,
    input  logic                   res_credit_i,
    output logic                   res_valid_o,
    output rv32_flow_pkg::tag_t    res_tag_o,
    output logic [`XLEN-1:0]       res_data_o
);
    import rv32_flow_pkg::*;

    logic             alu_valid, md_valid;
    tag_t             alu_tag, md_tag;
    logic [`XLEN-1:0] alu_data, md_data;

    // Both units see every issue and pick their own ops
    rv32_alu_pipe rv32_alu_pipe_i (.clk_i(clk_i),
                                   .rst_n_i(rst_n_i),
                                   .op_valid_i(issue_valid_i),
                                   .op_i(issue_op_i),
                                   .op_a_i(issue_a_i),
                                   .op_b_i(issue_b_i),
                                   .op_tag_i(issue_tag_i),
                                   .res_valid_o(alu_valid),
                                   .res_tag_o(alu_tag),
                                   .res_data_o(alu_data));

    rv32_mul_div rv32_mul_div_i (.clk_i(clk_i),
                                 .rst_n_i(rst_n_i),
                                 .op_valid_i(issue_valid_i),
                                 .op_i(issue_op_i),
                                 .op_a_i(issue_a_i),
                                 .op_b_i(issue_b_i),
                                 .op_tag_i(issue_tag_i),
                                 .res_valid_o(md_valid),
                                 .res_tag_o(md_tag),
                                 .res_data_o(md_data));

    rv32_result_merge rv32_result_merge_i (.clk_i(clk_i),
                                           .rst_n_i(rst_n_i),
                                           .alu_valid_i(alu_valid),
                                           .alu_tag_i(alu_tag),
                                           .alu_data_i(alu_data),
                                           .md_valid_i(md_valid),
                                           .md_tag_i(md_tag),
                                           .md_data_i(md_data),
                                           .res_credit_i(res_credit_i),
                                           .res_valid_o(res_valid_o),
                                           .res_tag_o(res_tag_o),
                                           .res_data_o(res_data_o),
                                           .issue_credit_o(issue_credit_o));

endmodule

/* src/rv32_flow_pkg.sv */
`include "rv32_exec_cfg.svh"

package rv32_flow_pkg;

    // Tag returned with each result
    typedef logic [`TAG_WIDTH-1:0] tag_t;

    // Counts 0 up to RESULT_DEPTH + 1
    typedef logic [$clog2(`RESULT_DEPTH + 2)-1:0] credit_t;

    typedef enum logic [1:0] {
        MD_IDLE = 2'b00,
        MD_MUL  = 2'b01,
        MD_DIV  = 2'b10,
        MD_DONE = 2'b11  // Result valid for one cycle
    } md_state_e;

endpackage

/* src/rv32_isa_pkg.sv */
package rv32_isa_pkg;

    // Low bits follow funct3, bit 3 is funct7[5] for SUB and SRA
    // Bit 4 marks the M extension
    typedef enum logic [4:0] {
        OP_ADD    = 5'b00000,
        OP_SLL    = 5'b00001,
        OP_SLT    = 5'b00010,
        OP_SLTU   = 5'b00011,
        OP_XOR    = 5'b00100,
        OP_SRL    = 5'b00101,
        OP_OR     = 5'b00110,
        OP_AND    = 5'b00111,
        OP_SUB    = 5'b01000,
        OP_SRA    = 5'b01101,

        OP_MUL    = 5'b10000,
        OP_MULH   = 5'b10001,
        OP_MULHSU = 5'b10010,
        OP_MULHU  = 5'b10011,
        OP_DIV    = 5'b10100,
        OP_DIVU   = 5'b10101,
        OP_REM    = 5'b10110,
        OP_REMU   = 5'b10111
    } exec_op_e;

    // Unit select, 1 routes the op to the mul/div unit
    function automatic logic is_muldiv(input exec_op_e op);
        return op[4];
    endfunction

endpackage

/* src/rv32_mul_div.sv */
`timescale 1ns/1ns
`include "rv32_exec_cfg.svh"

module rv32_mul_div (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   op_valid_i,
    input  rv32_isa_pkg::exec_op_e op_i,
    input  logic [`XLEN-1:0]       op_a_i,
    input  logic [`XLEN-1:0]       op_b_i,
    input  rv32_flow_pkg::tag_t    op_tag_i,
    output logic                   res_valid_o,
    output rv32_flow_pkg::tag_t    res_tag_o,
    output logic [`XLEN-1:0]       res_data_o
);
    import rv32_isa_pkg::*;
    import rv32_flow_pkg::*;

    localparam int QDEPTH = `ISSUE_CREDITS;
    localparam int QPTR_W = $clog2(QDEPTH);
    localparam int QCNT_W = QPTR_W + 1;

    exec_op_e           q_op  [QDEPTH];
    logic [`XLEN-1:0]   q_a   [QDEPTH];
    logic [`XLEN-1:0]   q_b   [QDEPTH];
    tag_t               q_tag [QDEPTH];
    logic [QPTR_W-1:0]  q_wr_ptr, q_rd_ptr;
    logic [QCNT_W-1:0]  q_count;
    logic               q_push, q_pop;

    exec_op_e           h_op;
    logic [`XLEN-1:0]   h_a, h_b;
    logic               h_signed, h_div0, h_ovf;

    md_state_e          state;
    exec_op_e           cur_op;
    logic [`XLEN-1:0]   cur_a, cur_b;
    logic [`XLEN-1:0]   quo, rem, divisor;
    logic               neg_q, neg_r;
    logic [$clog2(`XLEN):0] step;
    logic [`XLEN:0]     rem_shift, rem_trial;
    logic [`XLEN:0]     mul_a, mul_b;
    logic [2*`XLEN+1:0] product;

    assign q_push = op_valid_i && is_muldiv(op_i);
    assign q_pop  = (state == MD_IDLE) && (q_count != '0);

    // Op queue, issue order
    always_ff @(posedge clk_i) begin
        if (q_push) begin
            q_op[q_wr_ptr]  <= op_i;
            q_a[q_wr_ptr]   <= op_a_i;
            q_b[q_wr_ptr]   <= op_b_i;
            q_tag[q_wr_ptr] <= op_tag_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end else begin
            if (q_push) q_wr_ptr <= q_wr_ptr + 1'b1;
            if (q_pop)  q_rd_ptr <= q_rd_ptr + 1'b1;
            q_count <= q_count + QCNT_W'(q_push) - QCNT_W'(q_pop);
        end
    end

    assign h_op     = q_op[q_rd_ptr];
    assign h_a      = q_a[q_rd_ptr];
    assign h_b      = q_b[q_rd_ptr];
    assign h_signed = (h_op == OP_DIV) || (h_op == OP_REM);
    assign h_div0   = (h_b == '0);
    assign h_ovf    = h_signed && (h_a == {1'b1, {(`XLEN-1){1'b0}}}) && (h_b == '1);

    // 33-bit operands cover signed, mixed and unsigned products
    assign mul_a   = {(cur_op != OP_MULHU) && cur_a[`XLEN-1], cur_a};
    assign mul_b   = {(cur_op == OP_MULH) && cur_b[`XLEN-1], cur_b};
    assign product = $signed(mul_a) * $signed(mul_b);

    assign rem_shift = {rem, quo[`XLEN-1]};
    assign rem_trial = rem_shift - {1'b0, divisor};  // MSB set means no fit

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state <= MD_IDLE;
        end else begin
            case (state)
                MD_IDLE: if (q_pop) begin
                    if (!h_op[2])               state <= MD_MUL;
                    else if (h_div0 || h_ovf)   state <= MD_DONE;
                    else                        state <= MD_DIV;
                end
                MD_MUL:  state <= MD_DONE;
                MD_DIV:  if (step == `XLEN) state <= MD_DONE;
                default: state <= MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state)
            MD_IDLE: if (q_pop) begin
                cur_op    <= h_op;
                cur_a     <= h_a;
                cur_b     <= h_b;
                res_tag_o <= q_tag[q_rd_ptr];
                quo       <= (h_signed && h_a[`XLEN-1]) ? -h_a : h_a;
                divisor   <= (h_signed && h_b[`XLEN-1]) ? -h_b : h_b;
                rem       <= '0;
                step      <= '0;
                neg_q     <= h_signed && (h_a[`XLEN-1] ^ h_b[`XLEN-1]);
                neg_r     <= h_signed && h_a[`XLEN-1];
                // RISC-V corner cases finish without iterating
                if (h_div0) begin
                    res_data_o <= (h_op == OP_DIV || h_op == OP_DIVU) ? '1 : h_a;
                end else if (h_ovf) begin
                    res_data_o <= (h_op == OP_DIV) ? h_a : '0;
                end
            end
            MD_MUL: begin
                res_data_o <= (cur_op == OP_MUL) ? product[`XLEN-1:0]
                                                 : product[2*`XLEN-1:`XLEN];
            end
            MD_DIV: begin
                if (step != `XLEN) begin
                    rem  <= rem_trial[`XLEN] ? rem_shift[`XLEN-1:0] : rem_trial[`XLEN-1:0];
                    quo  <= {quo[`XLEN-2:0], ~rem_trial[`XLEN]};
                    step <= step + 1'b1;
                end else if (cur_op == OP_REM || cur_op == OP_REMU) begin
                    res_data_o <= neg_r ? -rem : rem;  // Sign fix-up
                end else begin
                    res_data_o <= neg_q ? -quo : quo;
                end
            end
            default: ;
        endcase
    end

    assign res_valid_o = (state == MD_DONE);

endmodule

/* src/rv32_result_merge.sv */
`timescale 1ns/1ns
`include "rv32_exec_cfg.svh"

module rv32_result_merge (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                alu_valid_i,
    input  rv32_flow_pkg::tag_t alu_tag_i,
    input  logic [`XLEN-1:0]    alu_data_i,
    input  logic                md_valid_i,
    input  rv32_flow_pkg::tag_t md_tag_i,
    input  logic [`XLEN-1:0]    md_data_i,
    input  logic                res_credit_i,
    output logic                res_valid_o,
    output rv32_flow_pkg::tag_t res_tag_o,
    output logic [`XLEN-1:0]    res_data_o,
    output logic                issue_credit_o
);
    import rv32_flow_pkg::*;

    localparam int PTR_W = $clog2(`RESULT_DEPTH);

    tag_t             buf_tag  [`RESULT_DEPTH];
    logic [`XLEN-1:0] buf_data [`RESULT_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W-1:0] md_slot;
    credit_t          fill;
    credit_t          credits;  // Consumer credits held
    logic             pop;

    // ALU result takes the first free slot on a double write
    assign md_slot = alu_valid_i ? wr_ptr + 1'b1 : wr_ptr;

    always_ff @(posedge clk_i) begin
        if (alu_valid_i) begin
            buf_tag[wr_ptr]  <= alu_tag_i;
            buf_data[wr_ptr] <= alu_data_i;
        end
        if (md_valid_i) begin
            buf_tag[md_slot]  <= md_tag_i;
            buf_data[md_slot] <= md_data_i;
        end
    end

    assign pop = (fill != '0) && (credits != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= '0;
        end else begin
            wr_ptr  <= wr_ptr + PTR_W'(alu_valid_i) + PTR_W'(md_valid_i);
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill    <= fill + credit_t'(alu_valid_i) + credit_t'(md_valid_i)
                       - credit_t'(pop);
            credits <= credits + credit_t'(res_credit_i) - credit_t'(pop);
        end
    end

    // Oldest entry goes out, freeing one issue slot
    assign res_valid_o    = pop;
    assign res_tag_o      = buf_tag[rd_ptr];
    assign res_data_o     = buf_data[rd_ptr];
    assign issue_credit_o = pop;

endmodule
